// File: build.f
+incdir+common
+incdir+verif
common/solver_pkg.sv
design/solver_ctrl.sv
search/digit_search.sv
permute/permute_search.sv
design/solver.sv
verif/tb_solver.sv

// File: common/solver_consts.svh
`ifndef SOLVER_CONSTS_SVH
`define SOLVER_CONSTS_SVH

// digits in one question
`define SOLVER_NUM_DIGITS 4

// legal digit values run from 0 to 9
`define SOLVER_RADIX 10

// the opening question 0123
`define SOLVER_INITIAL_QUESTION 16'h0123

// orderings of four distinct digits
`define SOLVER_NUM_ORDERS 24

`endif

// File: common/solver_pkg.sv
`default_nettype none

`include "solver_consts.svh"

package solver_pkg;

  typedef logic [3:0] digit_t;

  // position 3 sits in the most significant nibble
  typedef logic [`SOLVER_NUM_DIGITS*4-1:0] question_t;

  typedef logic [2:0] count_t;

  typedef logic [`SOLVER_RADIX-1:0] digit_mask_t;

  typedef logic [4:0] order_idx_t;

  typedef logic [1:0] pos_t;

  typedef enum logic [1:0] {
    PH_FIRST,
    PH_DIGITS,
    PH_ORDER,
    PH_SOLVED
  } phase_t;

endpackage

`default_nettype wire

// File: design/solver.sv
`timescale 1ns/1ns
`default_nettype none

module solver (
  input  wire logic               clk,
  input  wire logic               reset,
  input  wire logic               reply_valid,
  input  wire logic               reply_ready,
  input  wire logic               correct,
  input  wire solver_pkg::count_t strike,
  input  wire solver_pkg::count_t ball,
  output solver_pkg::question_t   question,
  output logic                    ask_valid,
  output logic                    ask_ready
);

  import solver_pkg::*;

  logic      reply_strobe;
  logic      order_step;
  logic      digits_found;
  phase_t    phase;
  question_t digit_question;
  question_t order_question;
  question_t found_digits;

  solver_ctrl i_ctrl (
    .clk            (clk),
    .reset          (reset),
    .reply_valid    (reply_valid),
    .reply_ready    (reply_ready),
    .correct        (correct),
    .digits_found   (digits_found),
    .digit_question (digit_question),
    .order_question (order_question),
    .reply_strobe   (reply_strobe),
    .order_step     (order_step),
    .question       (question),
    .ask_valid      (ask_valid),
    .ask_ready      (ask_ready),
    .phase          (phase)
  );

  digit_search i_digit_search (
    .clk            (clk),
    .reset          (reset),
    .reply_strobe   (reply_strobe),
    .strike         (strike),
    .ball           (ball),
    .phase          (phase),
    .digit_question (digit_question),
    .found_digits   (found_digits),
    .digits_found   (digits_found)
  );

  permute_search i_permute_search (
    .clk            (clk),
    .reset          (reset),
    .found_digits   (found_digits),
    .order_step     (order_step),
    .phase          (phase),
    .order_question (order_question)
  );

endmodule

`default_nettype wire

// File: design/solver_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

`include "solver_consts.svh"

module solver_ctrl (
  input  wire logic                  clk,
  input  wire logic                  reset,
  input  wire logic                  reply_valid,
  input  wire logic                  reply_ready,
  input  wire logic                  correct,
  input  wire logic                  digits_found,
  input  wire solver_pkg::question_t digit_question,
  input  wire solver_pkg::question_t order_question,
  output logic                       reply_strobe,
  output logic                       order_step,
  output solver_pkg::question_t      question,
  output logic                       ask_valid,
  output logic                       ask_ready,
  output solver_pkg::phase_t         phase
);

  import solver_pkg::*;

  // set while a new question still has to be put out
  logic      need_ask;
  question_t next_question;

  // a reply only counts while the question has been acknowledged
  assign reply_strobe = reply_valid && ask_ready && !correct;
  assign order_step   = reply_strobe && (phase == PH_ORDER);

  always_comb begin
    if (phase == PH_FIRST) begin
      next_question = `SOLVER_INITIAL_QUESTION;
    end else if (digits_found) begin
      next_question = order_question;
    end else begin
      next_question = digit_question;
    end
  end

  always_ff @(posedge clk) begin
    if (need_ask) begin
      question <= next_question;
    end
  end

  always_ff @(posedge clk) begin
    if (!reset) begin
      phase     <= PH_FIRST;
      need_ask  <= 1'b1;
      ask_valid <= 1'b0;
      ask_ready <= 1'b1;
    end else begin
      if (need_ask) begin
        need_ask  <= 1'b0;
        ask_valid <= 1'b1;
        ask_ready <= 1'b0;
        // the first question built from the ordering table starts the order phase
        if (digits_found) begin
          phase <= PH_ORDER;
        end
      end

      // grader has taken the question and is about to answer
      if (ask_valid && reply_ready && !reply_valid) begin
        ask_valid <= 1'b0;
        ask_ready <= 1'b1;
      end

      if (reply_valid && ask_ready) begin
        if (correct) begin
          phase <= PH_SOLVED;
        end else begin
          need_ask <= 1'b1;
          if (phase == PH_FIRST) begin
            phase <= PH_DIGITS;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: permute/permute_search.sv
`timescale 1ns/1ns
`default_nettype none

`include "solver_consts.svh"

module permute_search (
  input  wire logic                  clk,
  input  wire logic                  reset,
  input  wire solver_pkg::question_t found_digits,
  input  wire logic                  order_step,
  input  wire solver_pkg::phase_t    phase,
  output solver_pkg::question_t      order_question
);

  import solver_pkg::*;

  order_idx_t order_idx;

  // the source position for each output position is packed as {p3, p2, p1, p0}
  logic [7:0] order_sel;

  always_comb begin
    case (order_idx)
      5'd0:    order_sel = 8'b11_10_01_00;
      5'd1:    order_sel = 8'b11_10_00_01;
      5'd2:    order_sel = 8'b11_01_10_00;
      5'd3:    order_sel = 8'b11_01_00_10;
      5'd4:    order_sel = 8'b11_00_10_01;
      5'd5:    order_sel = 8'b11_00_01_10;
      5'd6:    order_sel = 8'b10_11_01_00;
      5'd7:    order_sel = 8'b10_11_00_01;
      5'd8:    order_sel = 8'b10_01_11_00;
      5'd9:    order_sel = 8'b10_01_00_11;
      5'd10:   order_sel = 8'b10_00_11_01;
      5'd11:   order_sel = 8'b10_00_01_11;
      5'd12:   order_sel = 8'b01_11_10_00;
      5'd13:   order_sel = 8'b01_11_00_10;
      5'd14:   order_sel = 8'b01_10_11_00;
      5'd15:   order_sel = 8'b01_10_00_11;
      5'd16:   order_sel = 8'b01_00_11_10;
      5'd17:   order_sel = 8'b01_00_10_11;
      5'd18:   order_sel = 8'b00_11_10_01;
      5'd19:   order_sel = 8'b00_11_01_10;
      5'd20:   order_sel = 8'b00_10_11_01;
      5'd21:   order_sel = 8'b00_10_01_11;
      5'd22:   order_sel = 8'b00_01_11_10;
      default: order_sel = 8'b00_01_10_11;
    endcase
  end

  always_comb begin
    for (int i = 0; i < `SOLVER_NUM_DIGITS; i++) begin
      order_question[4*i +: 4] = found_digits[4*order_sel[2*i +: 2] +: 4];
    end
  end

  // index 0 is the found guess itself and has already been asked
  always_ff @(posedge clk) begin
    if (!reset) begin
      order_idx <= 5'd1;
    end else if (phase != PH_ORDER) begin
      order_idx <= 5'd1;
    end else if (order_step && (order_idx < order_idx_t'(`SOLVER_NUM_ORDERS - 1))) begin
      order_idx <= order_idx + 5'd1;
    end
  end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# compile and run the solver testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ns --top-module tb_solver -f build.f -o tb_solver
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

out=$(./obj_dir/tb_solver)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Test OK"; then
  exit 0
fi
exit 1

// File: search/digit_search.sv
`timescale 1ns/1ns
`default_nettype none

`include "solver_consts.svh"

module digit_search (
  input  wire logic               clk,
  input  wire logic               reset,
  input  wire logic               reply_strobe,
  input  wire solver_pkg::count_t strike,
  input  wire solver_pkg::count_t ball,
  input  wire solver_pkg::phase_t phase,
  output solver_pkg::question_t   digit_question,
  output solver_pkg::question_t   found_digits,
  output logic                    digits_found
);

  import solver_pkg::*;

  question_t   ref_guess;
  count_t      ref_sum;
  count_t      sum;
  pos_t        pos;
  digit_t      last_try;
  digit_t      try_floor;
  digit_t      old_digit;
  digit_t      cand;
  digit_mask_t excl;
  digit_mask_t free;
  logic        has_more;

  assign sum          = strike + ball;
  assign found_digits = ref_guess;
  assign old_digit    = ref_guess[4*pos +: 4];

  // all ones in last_try means nothing was tried yet, so the floor wraps to zero
  assign try_floor = last_try + 4'd1;

  // digits still worth trying are neither excluded nor already in the reference guess
  always_comb begin
    for (int d = 0; d < `SOLVER_RADIX; d++) begin
      free[d] = !excl[d];
      for (int i = 0; i < `SOLVER_NUM_DIGITS; i++) begin
        if (ref_guess[4*i +: 4] == digit_t'(d)) begin
          free[d] = 1'b0;
        end
      end
    end
  end

  always_comb begin
    cand = '0;
    for (int d = `SOLVER_RADIX - 1; d >= 0; d--) begin
      if (free[d] && (digit_t'(d) >= try_floor)) begin
        cand = digit_t'(d);
      end
    end
    has_more = 1'b0;
    for (int d = 0; d < `SOLVER_RADIX; d++) begin
      if (free[d] && (digit_t'(d) > cand)) begin
        has_more = 1'b1;
      end
    end
  end

  always_comb begin
    digit_question = ref_guess;
    digit_question[4*pos +: 4] = cand;
  end

  // a rising sum also covers the sum of four, so the found guess lands here too
  always_ff @(posedge clk) begin
    if (reply_strobe) begin
      if (phase == PH_FIRST) begin
        ref_guess <= `SOLVER_INITIAL_QUESTION;
        ref_sum   <= sum;
      end else if ((phase == PH_DIGITS) && (sum > ref_sum)) begin
        ref_guess <= digit_question;
        ref_sum   <= sum;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!reset) begin
      pos          <= 2'd3;
      last_try     <= 4'hf;
      excl         <= '0;
      digits_found <= 1'b0;
    end else if (reply_strobe) begin
      if (phase == PH_FIRST) begin
        if (sum == count_t'(`SOLVER_NUM_DIGITS)) begin
          digits_found <= 1'b1;
        end
      end else if (phase == PH_DIGITS) begin
        if (sum == count_t'(`SOLVER_NUM_DIGITS)) begin
          digits_found <= 1'b1;
        end else if (sum > ref_sum) begin
          // the displaced digit is not in the secret
          excl[old_digit] <= 1'b1;
          pos             <= pos - 2'd1;
          last_try        <= 4'hf;
        end else begin
          if (sum < ref_sum) begin
            excl[cand] <= 1'b1;
          end
          if (has_more) begin
            last_try <= cand;
          end else begin
            pos      <= pos - 2'd1;
            last_try <= 4'hf;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: verif/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

task automatic check_question(input string what, input question_t exp, input question_t act);
  if (act !== exp) begin
    $display("ERR %s %s: expected %h, actual %h", test_name, what, exp, act);
    fail_now("question mismatch");
  end
endtask

task automatic check_count(input string what, input count_t exp, input count_t act);
  if (act !== exp) begin
    $display("ERR %s %s: expected %0d, actual %0d", test_name, what, exp, act);
    fail_now("count mismatch");
  end
endtask

task automatic check_flag(input string what, input logic exp, input logic act);
  if (act !== exp) begin
    $display("ERR %s %s: expected %b, actual %b", test_name, what, exp, act);
    fail_now("flag mismatch");
  end
endtask

// the grader counts each match once since the digits of both numbers are distinct
task automatic score_reply(input question_t q, input question_t s,
                           output count_t st, output count_t bl);
  st = '0;
  bl = '0;
  for (int i = 0; i < 4; i++) begin
    for (int j = 0; j < 4; j++) begin
      if (q[4*i +: 4] == s[4*j +: 4]) begin
        if (i == j) begin
          st = st + 3'd1;
        end else begin
          bl = bl + 3'd1;
        end
      end
    end
  end
endtask

function automatic logic digits_legal(input question_t q);
  logic ok;
  ok = 1'b1;
  for (int i = 0; i < 4; i++) begin
    if (q[4*i +: 4] > 4'd9) begin
      ok = 1'b0;
    end
    for (int j = i + 1; j < 4; j++) begin
      if (q[4*i +: 4] == q[4*j +: 4]) begin
        ok = 1'b0;
      end
    end
  end
  return ok;
endfunction

function automatic count_t count_diffs(input question_t a, input question_t b);
  count_t n;
  n = '0;
  for (int i = 0; i < 4; i++) begin
    if (a[4*i +: 4] != b[4*i +: 4]) begin
      n = n + 3'd1;
    end
  end
  return n;
endfunction

`endif

// File: verif/tb_solver.sv
`timescale 1ns/1ns
`default_nettype none

`include "solver_consts.svh"

module tb_solver;

  import solver_pkg::*;

  localparam int NUM_SECRETS     = 9;
  localparam int MAX_QUESTIONS   = 48;
  localparam int WATCHDOG_CYCLES = NUM_SECRETS * (MAX_QUESTIONS * 12 + 40);

  // each secret with the most questions it may take to solve
  question_t secret_tab [NUM_SECRETS] = '{16'h0123, 16'h6789, 16'h3210, 16'h9876, 16'h0987,
                                          16'h5086, 16'h2401, 16'h7319, 16'h4567};
  int        limit_tab  [NUM_SECRETS] = '{1, 13, 24, 48, 48, 48, 48, 48, 48};

  logic      clk;
  logic      reset;
  logic      reply_valid;
  logic      reply_ready;
  logic      correct;
  count_t    strike;
  count_t    ball;
  question_t question;
  logic      ask_valid;
  logic      ask_ready;
  int        seed = 32'h553b;
  string     test_name;

  solver i_dut (
    .clk         (clk),
    .reset       (reset),
    .reply_valid (reply_valid),
    .reply_ready (reply_ready),
    .correct     (correct),
    .strike      (strike),
    .ball        (ball),
    .question    (question),
    .ask_valid   (ask_valid),
    .ask_ready   (ask_ready)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // inputs change and outputs are read 5 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #5;
  endtask

  task automatic fail_now(input string reason);
    $display("Test FAILED");
    $fatal(1, reason);
  endtask

  `include "tb_checks.svh"

  task automatic run_secret(input int idx);
    question_t secret;
    question_t q;
    question_t ref_q;
    count_t    st;
    count_t    bl;
    count_t    sum;
    count_t    ref_sum;
    int        n_q;
    int        wait_cyc;
    logic      in_digits;
    logic      solved;
    secret    = secret_tab[idx];
    test_name = $sformatf("secret %h", secret);
    n_q       = 0;
    in_digits = 1'b1;
    solved    = 1'b0;
    ref_q     = '0;
    ref_sum   = '0;
    reset     = 1'b0;
    repeat (10) next_cycle();
    check_flag("ask_valid in reset", 1'b0, ask_valid);
    check_flag("ask_ready in reset", 1'b1, ask_ready);
    reset = 1'b1;
    next_cycle();
    check_flag("ask_valid after reset", 1'b1, ask_valid);
    while (!solved) begin
      while (!ask_valid) begin
        next_cycle();
      end
      q   = question;
      n_q = n_q + 1;
      check_flag("ask_ready while asking", 1'b0, ask_ready);
      if (n_q == 1) begin
        check_question("first question", `SOLVER_INITIAL_QUESTION, q);
      end
      check_flag("distinct legal digits", 1'b1, digits_legal(q));
      if (in_digits && (n_q > 1)) begin
        check_count("positions changed", 3'd1, count_diffs(q, ref_q));
      end
      // a slow grader leaves the question waiting
      wait_cyc = $unsigned($random(seed)) % 4;
      repeat (wait_cyc) begin
        next_cycle();
        check_flag("ask_valid held", 1'b1, ask_valid);
        check_question("question held", q, question);
      end
      reply_ready = 1'b1;
      next_cycle();
      reply_ready = 1'b0;
      check_flag("ask_valid after ack", 1'b0, ask_valid);
      check_flag("ask_ready after ack", 1'b1, ask_ready);
      wait_cyc = $unsigned($random(seed)) % 4;
      repeat (wait_cyc) begin
        next_cycle();
        check_flag("ask_valid before reply", 1'b0, ask_valid);
      end
      score_reply(q, secret, st, bl);
      sum         = st + bl;
      strike      = st;
      ball        = bl;
      correct     = (st == 3'd4);
      reply_valid = 1'b1;
      next_cycle();
      reply_valid = 1'b0;
      correct     = 1'b0;
      // the reference guess only moves when the sum rises
      if ((n_q == 1) || (in_digits && (sum > ref_sum))) begin
        ref_q   = q;
        ref_sum = sum;
      end
      if (sum == 3'd4) begin
        in_digits = 1'b0;
      end
      if (st == 3'd4) begin
        solved = 1'b1;
        check_question("solved question", secret, question);
        check_flag("question limit", 1'b1, n_q <= limit_tab[idx]);
      end
    end
    repeat (20) begin
      next_cycle();
      check_flag("ask_valid after solve", 1'b0, ask_valid);
    end
  endtask

  initial begin
    reset       = 1'b0;
    reply_valid = 1'b0;
    reply_ready = 1'b0;
    correct     = 1'b0;
    strike      = '0;
    ball        = '0;
    for (int k = 0; k < NUM_SECRETS; k++) begin
      run_secret(k);
    end
    $display("Test OK");
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, the secrets were not all solved",
             WATCHDOG_CYCLES);
    fail_now("timeout");
  end

endmodule

`default_nettype wire
